// File: source/cmd_receiver.sv
/* command receiver: byte counter and frame shift register,
   pulses when the eighth byte is in */
`timescale 1ns/10ps
`default_nettype none

module cmd_receiver (
   input  wire                        clk50,
   input  wire                        pllreset2,
   input  wire                        i_tvalid,
   input  wire  [7:0]                 i_tdata,
   input  wire                        i_rx_enable, // sequencer idle
   output logic                       o_tready,
   output scope_cmd_pkg::cmd_frame_u  o_frame,
   output logic                       o_frame_valid
);

   logic [2:0] byte_cnt;
   logic       accept;

   assign o_tready = i_rx_enable; // only take bytes while idle
   assign accept   = i_tvalid && i_rx_enable;

   // ==================== byte count
   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         byte_cnt      <= 3'd0;
         o_frame_valid <= 1'b0;
      end else begin
         o_frame_valid <= accept && (byte_cnt == 3'd7); // frame complete
         if (accept) begin
            if (byte_cnt == 3'd7)
               byte_cnt <= 3'd0; // ready for next frame
            else
               byte_cnt <= byte_cnt + 3'd1;
         end
      end
   end

   // new byte enters at the top, byte 0 ends up lowest
   always_ff @(posedge clk50) begin
      if (accept)
         o_frame.bytes <= {i_tdata, o_frame.bytes[7:1]};
   end

endmodule

`default_nettype wire

// File: source/command_sequencer.sv
/* command sequencer: idle, decode and reply FSM,
   opcode classification, register write strobe and reply setup */
`timescale 1ns/10ps
`default_nettype none

module command_sequencer (
   input  wire                        clk50,
   input  wire                        pllreset2,
   input  wire scope_cmd_pkg::cmd_frame_u i_frame,
   input  wire                        i_frame_valid,
   input  wire  [31:0]                i_reg_reply, // valid the cycle after reg_wr
   input  wire                        i_tx_done,
   output logic                       o_rx_enable,
   output logic                       o_reg_wr,
   output logic                       o_tx_start,
   output logic [31:0]                o_tx_len,
   output logic [31:0]                o_tx_word,
   output logic                       o_tx_mass
);
   import scope_cmd_pkg::*;

   localparam logic [1:0] S_IDLE   = 2'd0;
   localparam logic [1:0] S_DECODE = 2'd1;
   localparam logic [1:0] S_START  = 2'd2; // tx_start cycle
   localparam logic [1:0] S_WAIT   = 2'd3; // reply in flight

   // opcode classes
   localparam logic [1:0] K_REG  = 2'd0;
   localparam logic [1:0] K_DATE = 2'd1;
   localparam logic [1:0] K_MASS = 2'd2;
   localparam logic [1:0] K_NONE = 2'd3;

   logic [1:0]  state;
   logic [1:0]  kind;   // class of the frame on i_frame
   logic [1:0]  kind_q; // class of the reply being sent
   logic [31:0] len_q;

   always_comb begin
      case (i_frame.f.opcode)
         OP_ARM, OP_MISC, OP_TRIGGER,
         OP_DOWNSAMPLE, OP_BOARDOUT, OP_LEDS: kind = K_REG;
         OP_DATE:                             kind = K_DATE;
         OP_TX_MASS:                          kind = K_MASS;
         default:                             kind = K_NONE; // silently dropped
      endcase
   end

   // ==================== FSM
   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         state  <= S_IDLE;
         kind_q <= K_REG;
         len_q  <= 32'd0;
      end else begin
         case (state)
            S_IDLE: begin
               if (i_frame_valid)
                  state <= S_DECODE;
            end
            S_DECODE: begin
               kind_q <= kind;
               // mass length is bytes 1..4, little endian
               len_q  <= (kind == K_MASS) ? i_frame.bytes[4:1] : REPLY_LEN;
               state  <= (kind == K_NONE) ? S_IDLE : S_START;
            end
            S_START: state <= S_WAIT;
            S_WAIT: begin
               if (i_tx_done)
                  state <= S_IDLE;
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // low from the frame pulse on, so no byte slips in
   assign o_rx_enable = (state == S_IDLE) && !i_frame_valid;
   assign o_reg_wr    = (state == S_DECODE) && (kind == K_REG);
   assign o_tx_start  = (state == S_START);
   assign o_tx_len    = len_q;
   assign o_tx_mass   = (kind_q == K_MASS);
   assign o_tx_word   = (kind_q == K_DATE) ? FIRMWARE_DATE : i_reg_reply;

endmodule

`default_nettype wire

// File: source/response_streamer.sv
/* reply streamer: constant or counting pattern words
   with keep and last marks from the remaining byte count */
`timescale 1ns/10ps
`default_nettype none

module response_streamer (
   input  wire         clk50,
   input  wire         pllreset2,
   input  wire         i_tx_start,
   input  wire  [31:0] i_tx_len,  // bytes
   input  wire  [31:0] i_tx_word,
   input  wire         i_tx_mass, // counting pattern instead of the word
   input  wire         i_tready,
   output logic        o_tvalid,
   output logic [31:0] o_tdata,
   output logic [3:0]  o_tkeep,
   output logic        o_tlast,
   output logic        o_tx_done
);

   logic [31:0] rem_q;  // bytes still to send
   logic [31:0] word_q;
   logic        mass_q;
   logic [7:0]  r8;
   logic        accept;

   assign accept = o_tvalid && i_tready;
   assign r8     = rem_q[7:0];

   // ==================== count
   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         o_tvalid  <= 1'b0;
         o_tx_done <= 1'b0;
         rem_q     <= 32'd0;
         mass_q    <= 1'b0;
      end else begin
         o_tx_done <= accept && o_tlast;
         if (i_tx_start) begin
            o_tvalid <= 1'b1;
            rem_q    <= i_tx_len;
            mass_q   <= i_tx_mass;
         end else if (accept) begin
            if (o_tlast)
               o_tvalid <= 1'b0; // reply finished
            else
               rem_q <= rem_q - 32'd4;
         end
      end
   end

   always_ff @(posedge clk50) begin
      if (i_tx_start)
         word_q <= i_tx_word;
   end

   // bytes r-4 .. r-1, msb first
   assign o_tdata = mass_q ? {r8 - 8'd4, r8 - 8'd3, r8 - 8'd2, r8 - 8'd1} : word_q;
   assign o_tlast = o_tvalid && (rem_q <= 32'd4);

   always_comb begin
      if (rem_q >= 32'd4)
         o_tkeep = 4'b1111;
      else begin
         case (rem_q[1:0])
            2'd3:    o_tkeep = 4'b0111;
            2'd2:    o_tkeep = 4'b0011;
            2'd1:    o_tkeep = 4'b0001;
            default: o_tkeep = 4'b0000; // empty reply
         endcase
      end
   end

endmodule

`default_nettype wire

// File: source/scope_cmd_pkg.sv
/* opcodes and opcode 2 sub-command codes, reply constants,
   threshold width and the command frame union */
`default_nettype none

package scope_cmd_pkg;

   // ==================== opcodes
   localparam logic [7:0] OP_ARM        = 8'd1;  // arm trigger, set length
   localparam logic [7:0] OP_MISC       = 8'd2;  // readback and small settings
   localparam logic [7:0] OP_TRIGGER    = 8'd8;  // thresholds, ToT, channel
   localparam logic [7:0] OP_DOWNSAMPLE = 8'd9;
   localparam logic [7:0] OP_BOARDOUT   = 8'd10; // relay bits
   localparam logic [7:0] OP_LEDS       = 8'd11;
   localparam logic [7:0] OP_TX_MASS    = 8'h20; // bandwidth test
   localparam logic [7:0] OP_DATE       = 8'h23;

   // ==================== opcode 2 subs
   localparam logic [7:0] SUB_VERSION   = 8'd0;
   localparam logic [7:0] SUB_PRELEN    = 8'd7;
   localparam logic [7:0] SUB_ROLLING   = 8'd8;
   localparam logic [7:0] SUB_AUXSEL    = 8'd10;
   localparam logic [7:0] SUB_FIRSTLAST = 8'd14;

   // ==================== replies
   localparam logic [31:0] FIRMWARE_DATE = 32'h20251125;
   localparam logic [31:0] REPLY_LEN     = 32'd4; // one word, all bytes kept

   localparam int THRESH_W = 12; // one threshold half

   // eight-byte command frame, byte 0 received first
   typedef union packed {
      logic [7:0][7:0] bytes;
      struct packed {
         logic [5:0][7:0] args;   // args[0] is frame byte 2
         logic [7:0]      sub;    // byte 1
         logic [7:0]      opcode; // byte 0
      } f;
   } cmd_frame_u;

endpackage

`default_nettype wire

// File: source/scope_cmd_top.sv
/* command front end top level: receiver, sequencer,
   settings registers and reply streamer */
`timescale 1ns/10ps
`default_nettype none

module scope_cmd_top #(
   parameter logic [31:0] FW_VERSION        = 32'd32,
   parameter logic [15:0] PROBE_HALF_PERIOD = 16'd25000 // 1 kHz from 50 MHz
) (
   input  wire         clk50,
   input  wire         pllreset2,
   // command bytes in
   input  wire         i_tvalid,
   output logic        o_tready,
   input  wire  [7:0]  i_tdata,
   // reply words out
   output logic        o_tvalid,
   input  wire         i_tready,
   output logic [31:0] o_tdata,
   output logic [3:0]  o_tkeep,
   output logic        o_tlast,
   // triggerer side
   input  wire  [7:0]  i_acqstate,
   output logic signed [2*scope_cmd_pkg::THRESH_W-1:0] o_lowerthresh,
   output logic signed [2*scope_cmd_pkg::THRESH_W-1:0] o_upperthresh,
   output logic [15:0] o_lengthtotake,
   output logic [15:0] o_prelengthtotake,
   output logic        o_triggerlive,
   output logic [7:0]  o_triggertype,
   output logic [7:0]  o_triggertot,
   output logic        o_triggerchan,
   output logic [7:0]  o_channeltype,
   output logic        o_dorolling,
   output logic [3:0]  o_auxoutselector,
   output logic [1:0]  o_firstlast,
   output logic [4:0]  o_downsample,
   output logic        o_highres,
   output logic [7:0]  o_downsamplemerging,
   output logic [7:0]  o_boardout,
   output logic [23:0] o_neo_color0,
   output logic [23:0] o_neo_color1,
   output logic        o_send_color
);
   import scope_cmd_pkg::*;

   cmd_frame_u  frame;
   logic        frame_valid, rx_enable, reg_wr;
   logic [31:0] reg_reply;
   logic        tx_start, tx_mass, tx_done;
   logic [31:0] tx_len, tx_word;

   cmd_receiver u_rx (
      .clk50(clk50), .pllreset2(pllreset2),
      .i_tvalid(i_tvalid), .i_tdata(i_tdata), .i_rx_enable(rx_enable),
      .o_tready(o_tready), .o_frame(frame), .o_frame_valid(frame_valid)
   );

   command_sequencer u_seq (
      .clk50(clk50), .pllreset2(pllreset2),
      .i_frame(frame), .i_frame_valid(frame_valid),
      .i_reg_reply(reg_reply), .i_tx_done(tx_done),
      .o_rx_enable(rx_enable), .o_reg_wr(reg_wr),
      .o_tx_start(tx_start), .o_tx_len(tx_len), .o_tx_word(tx_word), .o_tx_mass(tx_mass)
   );

   scope_settings_regs #(
      .FW_VERSION(FW_VERSION),
      .PROBE_HALF_PERIOD(PROBE_HALF_PERIOD)
   ) u_regs (
      .clk50(clk50), .pllreset2(pllreset2),
      .i_frame(frame), .i_reg_wr(reg_wr), .i_acqstate(i_acqstate),
      .o_reg_reply(reg_reply),
      .o_lowerthresh(o_lowerthresh), .o_upperthresh(o_upperthresh),
      .o_lengthtotake(o_lengthtotake), .o_prelengthtotake(o_prelengthtotake),
      .o_triggerlive(o_triggerlive), .o_triggertype(o_triggertype),
      .o_triggertot(o_triggertot), .o_triggerchan(o_triggerchan),
      .o_channeltype(o_channeltype), .o_dorolling(o_dorolling),
      .o_auxoutselector(o_auxoutselector), .o_firstlast(o_firstlast),
      .o_downsample(o_downsample), .o_highres(o_highres),
      .o_downsamplemerging(o_downsamplemerging), .o_boardout(o_boardout),
      .o_neo_color0(o_neo_color0), .o_neo_color1(o_neo_color1),
      .o_send_color(o_send_color)
   );

   response_streamer u_tx (
      .clk50(clk50), .pllreset2(pllreset2),
      .i_tx_start(tx_start), .i_tx_len(tx_len), .i_tx_word(tx_word), .i_tx_mass(tx_mass),
      .i_tready(i_tready),
      .o_tvalid(o_tvalid), .o_tdata(o_tdata), .o_tkeep(o_tkeep), .o_tlast(o_tlast),
      .o_tx_done(tx_done)
   );

endmodule

`default_nettype wire

// File: source/scope_settings_regs.sv
/* trigger and acquisition settings registers, threshold arithmetic,
   readback reply word and the probe compensation square wave */
`timescale 1ns/10ps
`default_nettype none

module scope_settings_regs #(
   parameter logic [31:0] FW_VERSION        = 32'd32,
   parameter logic [15:0] PROBE_HALF_PERIOD = 16'd25000
) (
   input  wire                        clk50,
   input  wire                        pllreset2,
   input  wire scope_cmd_pkg::cmd_frame_u i_frame,
   input  wire                        i_reg_wr,
   input  wire  [7:0]                 i_acqstate, // already in clk50 domain
   output logic [31:0]                o_reg_reply,
   output logic signed [2*scope_cmd_pkg::THRESH_W-1:0] o_lowerthresh, // [23:12] runt half
   output logic signed [2*scope_cmd_pkg::THRESH_W-1:0] o_upperthresh,
   output logic [15:0]                o_lengthtotake,
   output logic [15:0]                o_prelengthtotake,
   output logic                       o_triggerlive,
   output logic [7:0]                 o_triggertype,
   output logic [7:0]                 o_triggertot,
   output logic                       o_triggerchan,
   output logic [7:0]                 o_channeltype,
   output logic                       o_dorolling,
   output logic [3:0]                 o_auxoutselector,
   output logic [1:0]                 o_firstlast,
   output logic [4:0]                 o_downsample,
   output logic                       o_highres,
   output logic [7:0]                 o_downsamplemerging,
   output logic [7:0]                 o_boardout, // bit 3 is the probe comp output
   output logic [23:0]                o_neo_color0,
   output logic [23:0]                o_neo_color1,
   output logic                       o_send_color
);
   import scope_cmd_pkg::*;

   logic [7:0]          b1, b2, b3, b4, b5, b6, b7;
   logic [THRESH_W-1:0] lvl, hys, runt;
   logic [THRESH_W-1:0] lo_thr, hi_thr, lo_thr2, hi_thr2;
   logic [31:0]         reply_d;
   logic [15:0]         probe_cnt;
   logic                probe_hit;

   assign b1 = i_frame.bytes[1];
   assign b2 = i_frame.bytes[2];
   assign b3 = i_frame.bytes[3];
   assign b4 = i_frame.bytes[4];
   assign b5 = i_frame.bytes[5];
   assign b6 = i_frame.bytes[6];
   assign b7 = i_frame.bytes[7];

   // ==================== thresholds
   assign lvl  = THRESH_W'(b1); // level
   assign hys  = THRESH_W'(b2); // hysteresis
   assign runt = THRESH_W'(b7); // runt width
   assign lo_thr = ((lvl - hys - THRESH_W'(128)) << 4) + THRESH_W'(8);
   assign hi_thr = ((lvl + hys - THRESH_W'(128)) << 4) + THRESH_W'(8);
   // b7 >= 128 turns runt rejection off, second half to full scale
   assign lo_thr2 = b7[7] ? {1'b1, {(THRESH_W-1){1'b0}}}
                          : ((lvl - hys - runt - THRESH_W'(128)) << 4) + THRESH_W'(8);
   assign hi_thr2 = b7[7] ? {1'b0, {(THRESH_W-1){1'b1}}}
                          : ((lvl + hys + runt - THRESH_W'(128)) << 4) + THRESH_W'(8);

   // reply from the values before this write
   always_comb begin
      case (i_frame.f.opcode)
         OP_ARM: reply_d = {24'd0, i_acqstate}; // lets host see an event is ready
         OP_MISC: begin
            case (i_frame.f.sub)
               SUB_VERSION:   reply_d = FW_VERSION;
               SUB_PRELEN:    reply_d = {16'd0, o_prelengthtotake};
               SUB_ROLLING:   reply_d = {31'd0, o_dorolling};
               SUB_AUXSEL:    reply_d = {28'd0, o_auxoutselector};
               SUB_FIRSTLAST: reply_d = {30'd0, o_firstlast};
               default:       reply_d = 32'd0;
            endcase
         end
         OP_TRIGGER:    reply_d = 32'd8;
         OP_DOWNSAMPLE: reply_d = 32'd9;
         OP_BOARDOUT:   reply_d = {24'd0, o_boardout & 8'hf7}; // probe bit hidden
         OP_LEDS:       reply_d = 32'd123;
         default:       reply_d = 32'd0;
      endcase
   end

   always_ff @(posedge clk50) begin
      if (i_reg_wr)
         o_reg_reply <= reply_d;
   end

   assign probe_hit = (probe_cnt == PROBE_HALF_PERIOD);

   // ==================== settings
   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         o_triggerlive       <= 1'b0;
         o_send_color        <= 1'b0;
         o_boardout          <= 8'd0;
         probe_cnt           <= 16'd0;
         o_triggertype       <= 8'd0;
         o_channeltype       <= 8'd0;
         o_lengthtotake      <= 16'd0;
         o_prelengthtotake   <= 16'd0;
         o_dorolling         <= 1'b0;
         o_auxoutselector    <= 4'd0;
         o_firstlast         <= 2'd0;
         o_lowerthresh       <= '0;
         o_upperthresh       <= '0;
         o_triggertot        <= 8'd0;
         o_triggerchan       <= 1'b0;
         o_downsample        <= 5'd0;
         o_highres           <= 1'b0;
         o_downsamplemerging <= 8'd0;
         o_neo_color0        <= 24'd0;
         o_neo_color1        <= 24'd0;
      end else begin
         if (probe_hit) begin // square wave for probe compensation
            probe_cnt     <= 16'd0;
            o_boardout[3] <= ~o_boardout[3];
         end else begin
            probe_cnt <= probe_cnt + 16'd1;
         end

         if (i_reg_wr) begin
            o_triggerlive <= 1'b0; // any command disarms
            case (i_frame.f.opcode)
               OP_ARM: begin
                  o_triggertype  <= b1;
                  o_channeltype  <= b2;
                  o_lengthtotake <= {b5, b4};
                  if (i_acqstate == 8'd0)
                     o_triggerlive <= 1'b1; // arm only when idle
               end
               OP_MISC: begin
                  case (i_frame.f.sub)
                     SUB_PRELEN:    o_prelengthtotake <= {b3, b2};
                     SUB_ROLLING:   o_dorolling       <= b2[0];
                     SUB_AUXSEL:    o_auxoutselector  <= b2[3:0];
                     SUB_FIRSTLAST: o_firstlast       <= b2[1:0];
                     default: ;
                  endcase
               end
               OP_TRIGGER: begin
                  o_lowerthresh <= {lo_thr2, lo_thr};
                  o_upperthresh <= {hi_thr2, hi_thr};
                  o_triggertot  <= b5;
                  o_triggerchan <= b6[0];
               end
               OP_DOWNSAMPLE: begin
                  o_downsample        <= b1[4:0];
                  o_highres           <= b2[0];
                  o_downsamplemerging <= b3;
               end
               OP_BOARDOUT: begin
                  if (b1[2:0] != 3'd3) // bit 3 belongs to the probe toggle
                     o_boardout[b1[2:0]] <= b2[0];
               end
               OP_LEDS: begin
                  o_neo_color0 <= {b4, b3, b2};
                  o_neo_color1 <= {b7, b6, b5};
                  o_send_color <= b1[0];
               end
               default: ;
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
/* testbench clock and reset generator with 10 ns clock and two-cycle reset */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
   output logic o_clk50,
   output logic o_pllreset2
);

   initial begin
      o_clk50 = 1'b0;
      forever #5 o_clk50 = ~o_clk50; // 10 ns period
   end

   // sync reset released on the second rising edge
   initial begin
      o_pllreset2 = 1'b1;
      repeat (2) @(posedge o_clk50);
      o_pllreset2 <= 1'b0;
   end

endmodule

`default_nettype wire

// File: tb/tb_scope_cmd.sv
/* testbench for the command front end with frame sender, reply model and comparator,
   threshold reference, watchdog and test report */
`timescale 1ns/10ps
`default_nettype none

module tb_scope_cmd;

   localparam logic [31:0] FW_VERSION_TB = 32'd32;
   localparam logic [31:0] FW_DATE       = 32'h20251125;
   localparam logic [31:0] LED_ACK       = 32'd123;        // fixed LED command answer
   localparam int          PROBE_HALF    = 50;
   localparam int          FRAME_TOTAL   = 9 + 2 + 2 + 3 + 5 + 2; // frames in tests 1..6
   localparam int          WATCHDOG_CYC  = FRAME_TOTAL * 200;
   localparam int          REPLY_TIMEOUT = 200;

   logic        clk50, pllreset2;
   logic        i_tvalid, o_tready, i_tready, o_tvalid, o_tlast;
   logic [7:0]  i_tdata, i_acqstate;
   logic [31:0] o_tdata;
   logic [3:0]  o_tkeep;
   logic [23:0] lowerthresh, upperthresh, neo_color0, neo_color1;
   logic [15:0] lengthtotake, prelengthtotake;
   logic [7:0]  triggertype, triggertot, channeltype, downsamplemerging, boardout;
   logic        triggerlive, triggerchan, dorolling, highres, send_color;
   logic [3:0]  auxoutselector;
   logic [1:0]  firstlast;
   logic [4:0]  downsample;

   // settings as the host believes them to be
   logic [7:0]  acq_model, boardout_model;
   logic [15:0] prelen_model;
   logic        rolling_model;
   logic [3:0]  auxsel_model;
   logic [1:0]  firstlast_model;

   logic [31:0] exp_data_q[$]; // expected reply words in order
   logic [3:0]  exp_keep_q[$];
   logic        exp_last_q[$];
   logic        stalled;
   logic [31:0] held_data;
   logic [3:0]  held_keep;
   int          errors, checks, test_errs;
   integer      seed = 32'h263f;

   tb_clock_gen u_clk (.o_clk50(clk50), .o_pllreset2(pllreset2));

   scope_cmd_top #(
      .FW_VERSION(FW_VERSION_TB),
      .PROBE_HALF_PERIOD(16'(PROBE_HALF)) // fast toggle for sim
   ) DUT (
      .clk50(clk50), .pllreset2(pllreset2),
      .i_tvalid(i_tvalid), .o_tready(o_tready), .i_tdata(i_tdata),
      .o_tvalid(o_tvalid), .i_tready(i_tready), .o_tdata(o_tdata),
      .o_tkeep(o_tkeep), .o_tlast(o_tlast), .i_acqstate(i_acqstate),
      .o_lowerthresh(lowerthresh), .o_upperthresh(upperthresh),
      .o_lengthtotake(lengthtotake), .o_prelengthtotake(prelengthtotake),
      .o_triggerlive(triggerlive), .o_triggertype(triggertype),
      .o_triggertot(triggertot), .o_triggerchan(triggerchan),
      .o_channeltype(channeltype), .o_dorolling(dorolling),
      .o_auxoutselector(auxoutselector), .o_firstlast(firstlast),
      .o_downsample(downsample), .o_highres(highres),
      .o_downsamplemerging(downsamplemerging), .o_boardout(boardout),
      .o_neo_color0(neo_color0), .o_neo_color1(neo_color1), .o_send_color(send_color)
   );

   task automatic check_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   // byte 0 lowest as received first
   function automatic logic [63:0] build_frame(input logic [7:0] b0, b1, b2, b3,
                                               input logic [7:0] b4, b5, b6, b7);
      return {b7, b6, b5, b4, b3, b2, b1, b0};
   endfunction

   // threshold pair from level, hysteresis and runt width mod 4096
   function automatic logic [23:0] thresh_ref(input logic [7:0] b1, b2, b7, input bit upper);
      logic [11:0] lvl, hys, runt, lo, hi;
      lvl  = {4'd0, b1};
      hys  = {4'd0, b2};
      runt = {4'd0, b7};
      if (upper) begin
         lo = (lvl + hys - 12'd128) * 12'd16 + 12'd8;
         hi = (lvl + hys + runt - 12'd128) * 12'd16 + 12'd8;
      end else begin
         lo = (lvl - hys - 12'd128) * 12'd16 + 12'd8;
         hi = (lvl - hys - runt - 12'd128) * 12'd16 + 12'd8;
      end
      if (b7 >= 8'd128)
         hi = upper ? 12'h7ff : 12'h800; // runt rejection off
      return {hi, lo};
   endfunction

   // reply word for a frame while rem bytes remain
   function automatic logic [31:0] expected_reply(input logic [63:0] frame,
                                                  input int unsigned rem);
      logic [31:0] pattern;
      int          k;
      pattern = 32'd0;
      case (frame[7:0])
         8'd1: return {24'd0, acq_model};
         8'd2: begin
            case (frame[15:8])
               8'd0:    return FW_VERSION_TB;
               8'd7:    return {16'd0, prelen_model};   // old value
               8'd8:    return {31'd0, rolling_model};
               8'd10:   return {28'd0, auxsel_model};
               8'd14:   return {30'd0, firstlast_model};
               default: return 32'd0;
            endcase
         end
         8'd8:    return 32'd8;
         8'd9:    return 32'd9;
         8'd10:   return {24'd0, boardout_model}; // bit 3 never set in model
         8'd11:   return LED_ACK;
         8'h20: begin
            for (k = 0; k < 4; k++)
               pattern[31-8*k -: 8] = 8'(rem - 4 + k); // msb holds byte rem-4
            return pattern;
         end
         8'h23:   return FW_DATE;
         default: return 32'd0;
      endcase
   endfunction

   task automatic queue_reply(input logic [63:0] frame);
      int unsigned rem;
      case (frame[7:0])
         8'h20:   rem = frame[39:8]; // bytes 1..4 little endian
         8'd1, 8'd2, 8'd8, 8'd9, 8'd10, 8'd11, 8'h23: rem = 4;
         default: rem = 0; // unknown opcode gets no reply
      endcase
      while (rem > 0) begin
         exp_data_q.push_back(expected_reply(frame, rem));
         exp_keep_q.push_back(rem >= 4 ? 4'b1111 : 4'b1111 >> (4 - rem));
         exp_last_q.push_back(rem <= 4);
         rem = (rem > 4) ? rem - 4 : 0;
      end
   endtask

   task automatic update_model(input logic [63:0] frame);
      logic [7:0] b1, b2, b3;
      b1 = frame[15:8];
      b2 = frame[23:16];
      b3 = frame[31:24];
      if (frame[7:0] == 8'd2) begin
         case (b1)
            8'd7:    prelen_model    = {b3, b2};
            8'd8:    rolling_model   = b2[0];
            8'd10:   auxsel_model    = b2[3:0];
            8'd14:   firstlast_model = b2[1:0];
            default: ;
         endcase
      end
      if (frame[7:0] == 8'd10 && b1[2:0] != 3'd3)
         boardout_model[b1[2:0]] = b2[0]; // bit 3 left to the probe wave
   endtask

   task automatic send_frame(input logic [63:0] frame);
      int idx;
      idx = 0;
      while (idx < 8) begin
         i_tvalid <= 1'b1;
         i_tdata  <= frame[8*idx +: 8];
         @(posedge clk50);
         if (o_tready) // taken on this edge
            idx++;
      end
      i_tvalid <= 1'b0;
   endtask

   task automatic wait_reply(input logic [7:0] opcode);
      int cyc;
      cyc = 0;
      while (exp_data_q.size() != 0 && cyc < REPLY_TIMEOUT) begin
         @(posedge clk50);
         cyc++;
      end
      assert (exp_data_q.size() == 0) else begin
         $display("reply to opcode %h did not finish within %0d cycles", opcode, REPLY_TIMEOUT);
         errors++;
         exp_data_q.delete();
         exp_keep_q.delete();
         exp_last_q.delete();
      end
      @(posedge clk50);
   endtask

   task automatic run_command(input logic [63:0] frame);
      queue_reply(frame);
      update_model(frame); // model moves on after queueing so readback sees old value
      send_frame(frame);
      wait_reply(frame[7:0]);
   endtask

   task automatic report_test(input int num, input string name);
      $display("test %0d %s: %0d errors", num, name, errors - test_errs);
      test_errs = errors;
   endtask

   // toggle every PROBE_HALF+1 cycles
   task automatic check_probe_toggle();
      int   cyc, last_cyc, toggles;
      logic prev;
      prev     = boardout[3];
      last_cyc = -1;
      toggles  = 0;
      for (cyc = 0; cyc < 250; cyc++) begin
         @(posedge clk50);
         if (boardout[3] !== prev) begin
            if (last_cyc >= 0)
               check_equal("o_boardout[3] toggle gap", cyc - last_cyc, PROBE_HALF + 1);
            last_cyc = cyc;
            toggles++;
            prev = boardout[3];
         end
      end
      assert (toggles >= 4) else begin
         $display("board output bit 3 toggled only %0d times in 250 cycles", toggles);
         errors++;
      end
   endtask

   // ==================== ready
   always @(posedge clk50) begin
      if (pllreset2)
         i_tready <= 1'b0;
      else
         i_tready <= (($random(seed) & 3) != 0); // ready about 3 cycles in 4
   end

   // ==================== compare
   always @(posedge clk50) begin
      if (pllreset2) begin
         stalled <= 1'b0;
      end else begin
         if (stalled) begin // word must hold while not taken
            check_equal("o_tvalid", o_tvalid, 1);
            check_equal("o_tdata", o_tdata, held_data);
            check_equal("o_tkeep", o_tkeep, held_keep);
         end
         stalled   <= o_tvalid && !i_tready;
         held_data <= o_tdata;
         held_keep <= o_tkeep;
         if (o_tvalid && i_tready) begin
            assert (exp_data_q.size() != 0) else begin
               $display("reply word %h arrived with no reply pending", o_tdata);
               errors++;
            end
            if (exp_data_q.size() != 0) begin
               check_equal("o_tdata", o_tdata, exp_data_q.pop_front());
               check_equal("o_tkeep", o_tkeep, exp_keep_q.pop_front());
               check_equal("o_tlast", o_tlast, exp_last_q.pop_front());
            end
         end
      end
   end

   initial begin : watchdog
      repeat (WATCHDOG_CYC) @(posedge clk50);
      $display("timeout, run did not finish within %0d cycles", WATCHDOG_CYC);
      $display(">>> FAIL");
      $finish;
   end

   // ==================== tests
   initial begin
      i_tvalid        = 1'b0;
      i_tdata         = 8'd0;
      i_tready        = 1'b0;
      i_acqstate      = 8'd0;
      acq_model       = 8'd0;
      boardout_model  = 8'd0;
      prelen_model    = 16'd0;
      rolling_model   = 1'b0;
      auxsel_model    = 4'd0;
      firstlast_model = 2'd0;
      errors          = 0;
      checks          = 0;
      test_errs       = 0;
      @(posedge clk50);
      while (pllreset2)
         @(posedge clk50);

      check_equal("o_tvalid", o_tvalid, 0); // reset state
      check_equal("o_tready", o_tready, 1);
      check_equal("o_triggerlive", triggerlive, 0);
      check_equal("o_send_color", send_color, 0);
      run_command(build_frame(2, 0, 0, 0, 0, 0, 0, 0)); // version
      run_command(build_frame(2, 7, 8'h34, 8'h12, 0, 0, 0, 0));
      run_command(build_frame(2, 7, 8'hcd, 8'hab, 0, 0, 0, 0));
      run_command(build_frame(2, 8, 1, 0, 0, 0, 0, 0));
      check_equal("o_dorolling", dorolling, rolling_model);
      run_command(build_frame(2, 8, 0, 0, 0, 0, 0, 0));
      run_command(build_frame(2, 10, 8'h0b, 0, 0, 0, 0, 0));
      run_command(build_frame(2, 10, 8'h05, 0, 0, 0, 0, 0));
      run_command(build_frame(2, 14, 2, 0, 0, 0, 0, 0));
      run_command(build_frame(2, 14, 1, 0, 0, 0, 0, 0));
      check_equal("o_prelengthtotake", prelengthtotake, prelen_model);
      check_equal("o_dorolling", dorolling, rolling_model);
      check_equal("o_auxoutselector", auxoutselector, auxsel_model);
      check_equal("o_firstlast", firstlast, firstlast_model);
      report_test(1, "misc readback");

      run_command(build_frame(8, 150, 10, 0, 0, 3, 1, 200)); // runt off
      check_equal("o_lowerthresh", lowerthresh, thresh_ref(150, 10, 200, 0));
      check_equal("o_upperthresh", upperthresh, thresh_ref(150, 10, 200, 1));
      check_equal("o_triggertot", triggertot, 3);
      check_equal("o_triggerchan", triggerchan, 1);
      run_command(build_frame(8, 100, 5, 0, 0, 7, 0, 20));
      check_equal("o_lowerthresh", lowerthresh, thresh_ref(100, 5, 20, 0));
      check_equal("o_upperthresh", upperthresh, thresh_ref(100, 5, 20, 1));
      check_equal("o_triggertot", triggertot, 7);
      check_equal("o_triggerchan", triggerchan, 0);
      report_test(2, "thresholds");

      run_command(build_frame(8'h20, 9, 0, 0, 0, 0, 0, 0)); // partial last word
      run_command(build_frame(8'h20, 16, 0, 0, 0, 0, 0, 0));
      report_test(3, "bandwidth pattern");

      acq_model  = 8'd0;
      i_acqstate <= 8'd0;
      run_command(build_frame(1, 8'h02, 8'h05, 0, 8'h34, 8'h12, 0, 0));
      check_equal("o_triggerlive", triggerlive, 1);
      check_equal("o_triggertype", triggertype, 8'h02);
      check_equal("o_channeltype", channeltype, 8'h05);
      check_equal("o_lengthtotake", lengthtotake, 16'h1234);
      run_command(build_frame(2, 0, 0, 0, 0, 0, 0, 0));
      check_equal("o_triggerlive", triggerlive, 0); // next command disarms
      acq_model  = 8'd3;
      i_acqstate <= 8'd3; // acquisition busy
      run_command(build_frame(1, 8'h01, 8'h0f, 0, 8'h00, 8'h08, 0, 0));
      check_equal("o_triggerlive", triggerlive, 0);
      report_test(4, "arm");

      run_command(build_frame(9, 8'h13, 1, 8'h44, 0, 0, 0, 0));
      check_equal("o_downsample", downsample, 5'h13);
      check_equal("o_highres", highres, 1);
      check_equal("o_downsamplemerging", downsamplemerging, 8'h44);
      run_command(build_frame(10, 0, 1, 0, 0, 0, 0, 0));
      run_command(build_frame(10, 5, 1, 0, 0, 0, 0, 0));
      run_command(build_frame(10, 3, 1, 0, 0, 0, 0, 0)); // probe bit is ignored
      check_equal("o_boardout", boardout & 8'hf7, boardout_model);
      run_command(build_frame(11, 1, 8'h11, 8'h22, 8'h33, 8'h44, 8'h55, 8'h66));
      check_equal("o_neo_color0", neo_color0, 24'h332211);
      check_equal("o_neo_color1", neo_color1, 24'h665544);
      check_equal("o_send_color", send_color, 1);
      check_probe_toggle();
      report_test(5, "outputs and probe wave");

      queue_reply(build_frame(8'h40, 0, 0, 0, 0, 0, 0, 0)); // queues nothing
      send_frame(build_frame(8'h40, 0, 0, 0, 0, 0, 0, 0));
      repeat (2) @(posedge clk50);
      check_equal("o_tready", o_tready, 0);
      @(posedge clk50);
      check_equal("o_tready", o_tready, 1); // back two cycles after frame pulse
      repeat (10) @(posedge clk50);          // stray words caught by compare
      run_command(build_frame(8'h23, 0, 0, 0, 0, 0, 0, 0));
      report_test(6, "unknown opcode and date");

      $display("tests 6, checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog.f
source/scope_cmd_pkg.sv
source/cmd_receiver.sv
source/command_sequencer.sv
source/scope_settings_regs.sv
source/response_streamer.sv
source/scope_cmd_top.sv
tb/tb_clock_gen.sv
tb/tb_scope_cmd.sv
